// ==== Bender.yml ====
package:
  name: mecobo

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/cmd_pkg.sv
      - hdl/pin_pkg.sv
      - hdl/host_bus_port.sv
      - hdl/cmd_fifo.sv
      - hdl/time_base.sv
      - hdl/dispatch_fsm.sv
      - hdl/pin_controller.sv
      - hdl/mecobo_core.sv
  - target: simulation
    files:
      - sim/mecobo_tb.sv

// ==== build.f ====
+incdir+hdl
hdl/cmd_pkg.sv
hdl/pin_pkg.sv
hdl/host_bus_port.sv
hdl/cmd_fifo.sv
hdl/time_base.sv
hdl/dispatch_fsm.sv
hdl/pin_controller.sv
hdl/mecobo_core.sv
sim/mecobo_tb.sv

// ==== hdl/cmd_fifo.sv ====
// command FIFO: show-ahead circular buffer of scheduled commands with flags
`timescale 1ns/1ns
`include "mecobo_settings.svh"

module cmd_fifo (
  input  logic                                      sys_clk,
  input  logic                                      global_clock_reset,
  input  logic                                      push,
  input  cmd_pkg::sched_cmd_t                       push_cmd,
  input  logic                                      pop,
  output cmd_pkg::sched_cmd_t                       head,
  output logic                                      empty,
  output logic                                      full,
  output logic                                      almost_full,
  output logic [$clog2(`MECOBO_FIFO_DEPTH + 1)-1:0] count
);

  localparam int DEPTH = `MECOBO_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  cmd_pkg::sched_cmd_t mem [DEPTH];
  logic [AW-1:0]       wr_ptr;
  logic [AW-1:0]       rd_ptr;
  logic                wr_en;
  logic                rd_en;

  // guard pointers against misuse
  assign wr_en = push && !full;
  assign rd_en = pop && !empty;

  // show-ahead, head valid whenever not empty
  assign head = mem[rd_ptr];

  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + AW'(wr_en);
      rd_ptr <= rd_ptr + AW'(rd_en);
      count  <= count + CW'(wr_en) - CW'(rd_en);
    end
  end

  assign empty       = (count == '0);
  assign full        = (count == CW'(DEPTH));
  // free entries at the margin or fewer
  assign almost_full = (count >= CW'(DEPTH - `MECOBO_ALMOST_FULL));

  a_no_pop_empty : assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    pop |-> !empty);

  a_no_push_full : assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    push |-> !full);

endmodule

// ==== hdl/cmd_pkg.sv ====
// command path types: host bus cycle, scheduled command and issued command
`include "mecobo_settings.svh"

package cmd_pkg;

  // one host bus cycle, strobes active high
  typedef struct packed {
    logic        cs;
    logic        wr;
    logic        rd;
    logic [7:0]  addr;
    logic [15:0] wdata;
  } host_req_t;

  // one queued command, as assembled from four host words
  typedef struct packed {
    logic [`MECOBO_TIME_W-1:0] timestamp;
    // target pin, or the time-clear code
    logic [7:0]                pin;
    logic [7:0]                reg_sel;
    logic [15:0]               data;
  } sched_cmd_t;

  // command as broadcast to the pin bank
  typedef struct packed {
    // one-cycle strobe per issued command
    logic        en;
    logic [7:0]  pin;
    logic [7:0]  reg_sel;
    logic [15:0] data;
  } cmd_bus_t;

endpackage

// ==== hdl/dispatch_fsm.sv ====
// dispatcher that pops commands, waits for their timestamps and issues them to the pins
`timescale 1ns/1ns
`include "mecobo_settings.svh"

module dispatch_fsm (
  input  logic                      sys_clk,
  input  logic                      global_clock_reset,
  input  cmd_pkg::sched_cmd_t       head,
  input  logic                      empty,
  output logic                      pop,
  input  logic [`MECOBO_TIME_W-1:0] now,
  output cmd_pkg::cmd_bus_t         cmd_bus,
  output logic                      time_clear
);

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_WAIT  = 2'd1,
    ST_ISSUE = 2'd2
  } state_t;

  state_t              state;
  cmd_pkg::sched_cmd_t cur;
  logic                is_clear;

  // latch and pop together and only from idle
  assign pop = (state == ST_IDLE) && !empty;

  assign is_clear = (cur.pin == `MECOBO_PIN_TIME_CLEAR);

  // held command loaded on pop
  always_ff @(posedge sys_clk) begin
    if (pop) begin
      cur <= head;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (!empty) begin
            state <= ST_WAIT;
          end
        end
        // past timestamps fall through on the next edge
        ST_WAIT: begin
          if (now >= cur.timestamp) begin
            state <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // one-cycle strobe for every command other than a time clear
  assign cmd_bus.en      = (state == ST_ISSUE) && !is_clear;
  assign cmd_bus.pin     = cur.pin;
  assign cmd_bus.reg_sel = cur.reg_sel;
  assign cmd_bus.data    = cur.data;

  // routed to time_base instead
  assign time_clear = (state == ST_ISSUE) && is_clear;

  // the bus only sees a command once now has moved past its timestamp
  a_not_early : assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    cmd_bus.en |-> now > cur.timestamp);

endmodule

// ==== hdl/host_bus_port.sv ====
// host bus port: builds scheduled commands from host words and serves status reads
`timescale 1ns/1ns
`include "mecobo_settings.svh"

module host_bus_port (
  input  logic                                      sys_clk,
  input  logic                                      global_clock_reset,
  input  cmd_pkg::host_req_t                        host,
  output logic [15:0]                               rdata,
  output logic                                      push,
  output cmd_pkg::sched_cmd_t                       push_cmd,
  input  logic                                      full,
  input  logic                                      empty,
  input  logic [$clog2(`MECOBO_FIFO_DEPTH + 1)-1:0] count
);

  localparam int CW = $clog2(`MECOBO_FIFO_DEPTH + 1);

  // staging words 0..2, word 3 comes straight off the bus
  logic [15:0] word0;
  logic [15:0] word1;
  logic [15:0] word2;
  logic        overflow;
  logic        wr_cmd;
  logic [15:0] status;

  // last word of a command
  assign wr_cmd = host.cs && host.wr && (host.addr == 8'd3);

  // push on the same edge as the word 3 write
  assign push = wr_cmd && !full;

  assign push_cmd.timestamp = {word1, word0};
  assign push_cmd.pin       = word2[15:8];
  assign push_cmd.reg_sel   = word2[7:0];
  assign push_cmd.data      = host.wdata;

  always_ff @(posedge sys_clk) begin
    if (host.cs && host.wr) begin
      case (host.addr)
        8'd0: word0 <= host.wdata;
        8'd1: word1 <= host.wdata;
        8'd2: word2 <= host.wdata;
        default: ;
      endcase
    end
  end

  // sticky until reset
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      overflow <= 1'b0;
    end else if (wr_cmd && full) begin
      overflow <= 1'b1;
    end
  end

  // status word layout
  always_comb begin
    status         = '0;
    status[0]      = empty;
    status[1]      = full;
    status[2]      = overflow;
    status[8 +: CW] = count;
  end

  // read data one cycle after the strobe, zero otherwise
  always_ff @(posedge sys_clk) begin
    if (host.cs && host.rd && (host.addr == 8'(`MECOBO_ADDR_STATUS))) begin
      rdata <= status;
    end else begin
      rdata <= '0;
    end
  end

  // host never drives both strobes in a selected cycle
  a_no_wr_rd : assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    host.cs |-> !(host.wr && host.rd));

endmodule

// ==== hdl/mecobo_core.sv ====
// mecobo core: host port, command FIFO, time base, dispatcher and pin bank
`timescale 1ns/1ns
`include "mecobo_settings.svh"

module mecobo_core (
  input  logic                        sys_clk,
  input  logic                        global_clock_reset,
  input  cmd_pkg::host_req_t          host,
  output logic [15:0]                 rdata,
  output logic                        irq,
  output logic                        heartbeat,
  output logic [`MECOBO_NUM_PINS-1:0] pins
);

  localparam int CW = $clog2(`MECOBO_FIFO_DEPTH + 1);

  logic                      push;
  cmd_pkg::sched_cmd_t       push_cmd;
  logic                      pop;
  cmd_pkg::sched_cmd_t       head;
  logic                      empty;
  logic                      full;
  logic [CW-1:0]             count;
  logic [`MECOBO_TIME_W-1:0] now;
  logic                      time_clear;
  cmd_pkg::cmd_bus_t         cmd_bus;

  time_base u_time_base (
    .sys_clk(sys_clk), .global_clock_reset(global_clock_reset),
    .time_clear(time_clear), .now(now), .heartbeat(heartbeat)
  );

  host_bus_port u_host (
    .sys_clk(sys_clk), .global_clock_reset(global_clock_reset),
    .host(host), .rdata(rdata), .push(push), .push_cmd(push_cmd),
    .full(full), .empty(empty), .count(count)
  );

  // irq straight from the fill margin flag
  cmd_fifo u_fifo (
    .sys_clk(sys_clk), .global_clock_reset(global_clock_reset),
    .push(push), .push_cmd(push_cmd), .pop(pop), .head(head),
    .empty(empty), .full(full), .almost_full(irq), .count(count)
  );

  dispatch_fsm u_dispatch (
    .sys_clk(sys_clk), .global_clock_reset(global_clock_reset),
    .head(head), .empty(empty), .pop(pop), .now(now),
    .cmd_bus(cmd_bus), .time_clear(time_clear)
  );

  // one controller per pin on the shared command bus
  for (genvar i = 0; i < `MECOBO_NUM_PINS; i++) begin : g_pin
    pin_controller #(.POSITION(i)) u_pc (
      .sys_clk(sys_clk), .global_clock_reset(global_clock_reset),
      .cmd_bus(cmd_bus), .pin(pins[i])
    );
  end

endmodule

// ==== hdl/mecobo_settings.svh ====
// mecobo build settings: pin count, command FIFO sizing, time width, host map
`ifndef MECOBO_SETTINGS_SVH
`define MECOBO_SETTINGS_SVH

// number of pin controllers on the shared command bus
`define MECOBO_NUM_PINS 16

// command FIFO entries, power of two
`define MECOBO_FIFO_DEPTH 8

// free entries at or below which irq is raised
`define MECOBO_ALMOST_FULL 2

// global time counter width
`define MECOBO_TIME_W 32

// host read address of the status word
`define MECOBO_ADDR_STATUS 4

// pin field value reserved for the time-clear command
`define MECOBO_PIN_TIME_CLEAR 8'hFF

`endif

// ==== hdl/pin_controller.sv ====
// pin controller: decodes its register writes and generates the pin waveform
`timescale 1ns/1ns

module pin_controller #(
  parameter int POSITION = 0
) (
  input  logic              sys_clk,
  input  logic              global_clock_reset,
  input  cmd_pkg::cmd_bus_t cmd_bus,
  output logic              pin
);

  pin_pkg::pin_regs_t regs;
  pin_pkg::pin_regs_t regs_nxt;
  logic [15:0]        phase;
  logic [15:0]        phase_nxt;
  logic               sq;
  logic               sq_nxt;
  logic               pin_nxt;
  logic               load;

  // addressed to this pin only
  assign load = cmd_bus.en && (cmd_bus.pin == 8'(POSITION));

  // register decode
  always_comb begin
    regs_nxt = regs;
    if (load) begin
      case (cmd_bus.reg_sel)
        8'd0: regs_nxt.mode = pin_pkg::wave_mode_t'(cmd_bus.data[1:0]);
        8'd1: regs_nxt.period = cmd_bus.data;
        8'd2: regs_nxt.duty = cmd_bus.data;
        8'd3: regs_nxt.level = cmd_bus.data;
        default: ;
      endcase
    end
  end

  // phase counter restarts on every write to this pin
  always_comb begin
    if (load) begin
      phase_nxt = '0;
      sq_nxt    = 1'b0;
    end else if (phase >= regs.period - 16'd1) begin
      // end of half wave or pwm frame
      phase_nxt = '0;
      sq_nxt    = ~sq;
    end else begin
      phase_nxt = phase + 16'd1;
      sq_nxt    = sq;
    end
  end

  // output from the updated registers so a write shows on the same edge
  always_comb begin
    case (regs_nxt.mode)
      pin_pkg::MODE_CONSTANT: pin_nxt = regs_nxt.level[0];
      pin_pkg::MODE_SQUARE:   pin_nxt = sq_nxt;
      pin_pkg::MODE_PWM:      pin_nxt = (phase_nxt < regs_nxt.duty);
      default:                pin_nxt = 1'b0;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      regs.mode <= pin_pkg::MODE_OFF;
      phase     <= '0;
      sq        <= 1'b0;
      pin       <= 1'b0;
    end else begin
      regs  <= regs_nxt;
      phase <= phase_nxt;
      sq    <= sq_nxt;
      pin   <= pin_nxt;
    end
  end

  // pwm frame must hold its duty
  a_duty_fits : assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    (regs.mode == pin_pkg::MODE_PWM) |-> (regs.duty <= regs.period));

endmodule

// ==== hdl/pin_pkg.sv ====
// pin controller types: waveform mode encoding and per-pin register set

package pin_pkg;

  // waveform selection, written through reg_sel 0
  typedef enum logic [1:0] {
    MODE_OFF      = 2'd0,
    MODE_CONSTANT = 2'd1,
    MODE_SQUARE   = 2'd2,
    MODE_PWM      = 2'd3
  } wave_mode_t;

  // register set of one pin
  typedef struct packed {
    wave_mode_t  mode;
    // cycles per half wave in square, cycles per frame in pwm
    logic [15:0] period;
    // high cycles per pwm frame
    logic [15:0] duty;
    // bit 0 is the constant output level
    logic [15:0] level;
  } pin_regs_t;

endpackage

// ==== hdl/time_base.sv ====
// time base: clearable global time counter and liveness heartbeat divider
`timescale 1ns/1ns
`include "mecobo_settings.svh"

module time_base (
  input  logic                      sys_clk,
  input  logic                      global_clock_reset,
  input  logic                      time_clear,
  output logic [`MECOBO_TIME_W-1:0] now,
  output logic                      heartbeat
);

  logic [23:0] beat_div;

  // schedule reference, restarts at 0 on a clear command
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset || time_clear) begin
      now <= '0;
    end else begin
      now <= now + 1'b1;
    end
  end

  // slow blink, unaffected by time clear
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      beat_div <= '0;
    end else begin
      beat_div <= beat_div + 1'b1;
    end
  end

  assign heartbeat = beat_div[23];

endmodule

// ==== sim/mecobo_tb.sv ====
// testbench for the mecobo core with host bus stimulus, scheduled pin checks and status readback
`timescale 1ns/1ns
`include "mecobo_settings.svh"

module mecobo_tb;

  localparam int DEPTH     = `MECOBO_FIFO_DEPTH;
  localparam int IRQ_LEVEL = `MECOBO_FIFO_DEPTH - `MECOBO_ALMOST_FULL;
  // six tests each well under this many scheduled cycles plus reset and margin
  localparam int TEST_BUDGET    = 3000;
  localparam int TIMEOUT_CYCLES = 6 * TEST_BUDGET + 2000;

  logic                        sys_clk;
  logic                        global_clock_reset;
  cmd_pkg::host_req_t          host;
  logic [15:0]                 rdata;
  logic                        irq;
  logic                        heartbeat;
  logic [`MECOBO_NUM_PINS-1:0] pins;

  // cycles since reset release track dut time until the first clear
  int cyc = 0;
  int run_cycles = 0;
  int errors = 0;
  int checks = 0;
  integer seed;
  // pins a test has programmed
  logic [`MECOBO_NUM_PINS-1:0] active_mask;
  // early-fire watch for the constant test
  logic early_watch;
  int   early_pin;
  int   early_time;

  mecobo_core dut (
    .sys_clk(sys_clk),
    .global_clock_reset(global_clock_reset),
    .host(host),
    .rdata(rdata),
    .irq(irq),
    .heartbeat(heartbeat),
    .pins(pins)
  );

  always #10 sys_clk = ~sys_clk;

  // time mirror and run limit
  always @(posedge sys_clk) begin
    run_cycles <= run_cycles + 1;
    if (global_clock_reset) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
    if (run_cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped: no result after %0d cycles", run_cycles);
      $display("Test failed");
      $finish;
    end
  end

  // untouched pins stay low
  a_quiet_pins : assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    (pins & ~active_mask) == '0)
    else begin
      errors++;
      $display("ERR quiet_pins expected 0 actual %h", $sampled(pins & ~active_mask));
    end

  // no pin change ahead of its timestamp
  a_not_early : assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    (early_watch && cyc < early_time) |-> !pins[early_pin])
    else begin
      errors++;
      $display("ERR early_pin expected 0 actual %0b", $sampled(pins[early_pin]));
    end

  // heartbeat is the top bit of a 24-bit divider counting from reset release
  a_heartbeat : assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    heartbeat == cyc[23])
    else begin
      errors++;
      $display("ERR heartbeat expected %0b actual %0b", $sampled(cyc[23]),
               $sampled(heartbeat));
    end

  // one write cycle and then an idle bus cycle
  task automatic host_write(input logic [7:0] addr, input logic [15:0] data);
    @(negedge sys_clk);
    host.cs    <= 1'b1;
    host.wr    <= 1'b1;
    host.rd    <= 1'b0;
    host.addr  <= addr;
    host.wdata <= data;
    @(negedge sys_clk);
    host <= '0;
  endtask

  // word 3 pushes so the task returns just after the push edge
  task automatic send_cmd(input logic [31:0] ts, input logic [7:0] pin,
                          input logic [7:0] reg_sel, input logic [15:0] data);
    host_write(8'd0, ts[15:0]);
    host_write(8'd1, ts[31:16]);
    host_write(8'd2, {pin, reg_sel});
    host_write(8'd3, data);
  endtask

  // status shows up one cycle after the strobe
  task automatic read_status(output logic [15:0] status);
    @(negedge sys_clk);
    host.cs   <= 1'b1;
    host.wr   <= 1'b0;
    host.rd   <= 1'b1;
    host.addr <= 8'(`MECOBO_ADDR_STATUS);
    @(negedge sys_clk);
    host <= '0;
    status = rdata;
  endtask

  // empty, full, overflow in bits 2:0, occupancy in 11:8
  function automatic logic [15:0] status_word(input logic empty, input logic full,
                                              input logic ovf, input int count);
    logic [15:0] w;
    w        = '0;
    w[0]     = empty;
    w[1]     = full;
    w[2]     = ovf;
    w[11:8]  = count[3:0];
    return w;
  endfunction

  task automatic expect_value(input string name, input int expected, input int actual);
    checks++;
    assert (actual == expected)
      else begin
        errors++;
        $display("ERR %s expected %0d actual %0d", name, expected, actual);
      end
  endtask

  task automatic check_range(input string name, input int lo, input int hi,
                             input int actual);
    checks++;
    assert (actual >= lo && actual <= hi)
      else begin
        errors++;
        $display("ERR %s expected %0d..%0d actual %0d", name, lo, hi, actual);
      end
  endtask

  // samples on falling edges and returns the cycle the level was first seen
  task automatic wait_pin_level(input int idx, input logic level, input int limit,
                                output int seen_at);
    int n;
    n = 0;
    while (pins[idx] !== level && n < limit) begin
      @(negedge sys_clk);
      n++;
    end
    seen_at = cyc;
    checks++;
    assert (pins[idx] === level)
      else begin
        errors++;
        $display("pin %0d never went to %0b within %0d cycles", idx, level, limit);
      end
  endtask

  task automatic report_test(input int num, input string name, input int base);
    $display("test %0d %s done, %0d errors", num, name, errors - base);
  endtask

  initial begin
    logic [15:0] status;
    int rnd, base, pin_a, t_fire, per, duty, highs, occ, near_ts, cp;
    int rise, fall, rise2;
    sys_clk            = 1'b0;
    global_clock_reset = 1'b1;
    host               = '0;
    seed               = 42021;
    active_mask        = '0;
    early_watch        = 1'b0;
    early_pin          = 0;
    early_time         = 0;
    repeat (16) @(posedge sys_clk);
    @(negedge sys_clk);
    global_clock_reset <= 1'b0;

    // idle state after reset
    base = errors;
    read_status(status);
    expect_value("reset_status", status_word(1'b1, 1'b0, 1'b0, 0), status);
    expect_value("reset_pins", 0, pins);
    expect_value("reset_irq", 0, irq);
    report_test(1, "reset", base);

    // constant level with the mode switch scheduled in the future
    base   = errors;
    rnd    = $random(seed);
    pin_a  = rnd & 3;
    t_fire = cyc + 60 + ((rnd >> 4) & 31);
    active_mask[pin_a] = 1'b1;
    early_pin   = pin_a;
    early_time  = t_fire;
    early_watch = 1'b1;
    send_cmd(32'd0, 8'(pin_a), 8'd3, 16'd1);
    send_cmd(32'(t_fire), 8'(pin_a), 8'd0, 16'(pin_pkg::MODE_CONSTANT));
    wait_pin_level(pin_a, 1'b1, t_fire - cyc + 20, rise);
    check_range("constant_rise", t_fire + 1, t_fire + 3, rise);
    early_watch = 1'b0;
    report_test(2, "constant", base);

    // square wave with a half period of per cycles
    base  = errors;
    rnd   = $random(seed);
    pin_a = 4 + (rnd & 3);
    per   = 3 + ((rnd >> 4) & 7);
    active_mask[pin_a] = 1'b1;
    send_cmd(32'd0, 8'(pin_a), 8'd1, 16'(per));
    send_cmd(32'd0, 8'(pin_a), 8'd0, 16'(pin_pkg::MODE_SQUARE));
    wait_pin_level(pin_a, 1'b1, 4 * per + 20, rise);
    wait_pin_level(pin_a, 1'b0, 2 * per + 4, fall);
    wait_pin_level(pin_a, 1'b1, 2 * per + 4, rise2);
    expect_value("square_high", per, fall - rise);
    expect_value("square_low", per, rise2 - fall);
    report_test(3, "square", base);

    // pwm with duty strictly inside the frame so both edges exist
    base  = errors;
    rnd   = $random(seed);
    pin_a = 8 + (rnd & 3);
    per   = 4 + ((rnd >> 4) & 15);
    duty  = 1 + (((rnd >> 8) & 255) % (per - 1));
    active_mask[pin_a] = 1'b1;
    send_cmd(32'd0, 8'(pin_a), 8'd1, 16'(per));
    send_cmd(32'd0, 8'(pin_a), 8'd2, 16'(duty));
    send_cmd(32'd0, 8'(pin_a), 8'd0, 16'(pin_pkg::MODE_PWM));
    wait_pin_level(pin_a, 1'b1, 40, rise);
    for (int w = 0; w < 3; w++) begin
      highs = 0;
      repeat (per) begin
        if (pins[pin_a]) begin
          highs++;
        end
        @(negedge sys_clk);
      end
      expect_value("pwm_window", duty, highs);
    end
    report_test(4, "pwm", base);

    // time clear followed by a small timestamp relative to the cleared time
    base    = errors;
    rnd     = $random(seed);
    pin_a   = 12 + (rnd & 3);
    near_ts = 20 + ((rnd >> 4) & 15);
    active_mask[pin_a] = 1'b1;
    send_cmd(32'd0, 8'(pin_a), 8'd3, 16'd1);
    send_cmd(32'd0, `MECOBO_PIN_TIME_CLEAR, 8'd0, 16'd0);
    // idle dispatcher pops, passes wait and issues, and time is 0 one edge later
    cp = cyc + 3;
    send_cmd(32'(near_ts), 8'(pin_a), 8'd0, 16'(pin_pkg::MODE_CONSTANT));
    wait_pin_level(pin_a, 1'b1, near_ts + 40, rise);
    check_range("clear_fire", near_ts + 1, near_ts + 3, rise - cp);
    report_test(5, "time_clear", base);

    // far-future commands back up the FIFO
    base = errors;
    for (int k = 1; k <= DEPTH + 1; k++) begin
      send_cmd(32'hFFFF_0000, 8'd0, 8'd0, 16'd0);
      // the first command leaves the FIFO once the dispatcher takes it
      occ = (k == 1) ? 1 : k - 1;
      expect_value("irq_level", int'(occ >= IRQ_LEVEL), irq);
    end
    read_status(status);
    expect_value("full_status", status_word(1'b0, 1'b1, 1'b0, DEPTH), status);
    send_cmd(32'hFFFF_0000, 8'd0, 8'd0, 16'd0);
    read_status(status);
    expect_value("overflow_status", status_word(1'b0, 1'b1, 1'b1, DEPTH), status);
    report_test(6, "overflow", base);

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
